// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tbCpu
FILELIST = all.f

.PHONY: all run build lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// File: all.f
+incdir+.
cpuPkg.sv
stageIf.sv
fetchUnit.sv
regFile.sv
decodeExecute.sv
memWriteback.sv
cpuTop.sv
tbCpu.sv

// File: cpuPkg.sv
package cpuPkg;

   // Word and register file geometry
   localparam int xlen     = 32;
   localparam int regAddrW = 3;
   localparam int numRegs  = 1 << regAddrW;

   // Major opcodes of the supported RV32I subset
   typedef enum logic [6:0] {
      OP     = 7'b0110011,
      OPIMM  = 7'b0010011,
      LOAD   = 7'b0000011,
      STORE  = 7'b0100011,
      BRANCH = 7'b1100011,
      JAL    = 7'b1101111
   } opcodeT;

   typedef enum logic [2:0] {
      ADD = 3'd0,
      SUB = 3'd1,
      AND = 3'd2,
      OR  = 3'd3,
      XOR = 3'd4,
      SLT = 3'd5
   } aluOpT;

   // funct3 values for OP and OPIMM
   localparam logic [2:0] f3AddSub = 3'b000;
   localparam logic [2:0] f3Slt    = 3'b010;
   localparam logic [2:0] f3Xor    = 3'b100;
   localparam logic [2:0] f3Or     = 3'b110;
   localparam logic [2:0] f3And    = 3'b111;

   // funct3 values for BRANCH
   localparam logic [2:0] f3Beq = 3'b000;
   localparam logic [2:0] f3Bne = 3'b001;

   // funct3 for word loads and stores
   localparam logic [2:0] f3Word = 3'b010;

   // funct7 selecting SUB over ADD
   localparam logic [6:0] f7Sub = 7'b0100000;

   // PC step per instruction
   localparam logic [xlen-1:0] instrBytes = 4;

endpackage

// File: cpuTop.sv
`timescale 1ns/100ps

module cpuTop import cpuPkg::*; #(
   parameter int imemWords = 256,
   parameter int dmemWords = 256
) (
   input  logic                clk,
   input  logic                rstN,
   input  logic                progWe,
   input  logic [xlen-1:0]     progAddr,
   input  logic [xlen-1:0]     progData,
   output logic                retireValid,
   output logic [xlen-1:0]     retirePc,
   output logic                retireRegWrite,
   output logic [regAddrW-1:0] retireRd,
   output logic [xlen-1:0]     retireData,
   output logic                retireMemRead,
   output logic                retireMemWrite,
   output logic [xlen-1:0]     retireAddr,
   output logic [xlen-1:0]     retireStoreData,
   input  logic                retireReady
);

   fetchDecodeIf fdBus ();
   execMemIf     emBus ();

   // One freeze condition for the whole pipeline
   assign fdBus.advance = emBus.advance;

   fetchUnit #(.imemWords(imemWords)) fetch_i (
      .clk      (clk),
      .rstN     (rstN),
      .progWe   (progWe),
      .progAddr (progAddr),
      .progData (progData),
      .fd       (fdBus.fetch)
   );

   decodeExecute decode_i (
      .clk  (clk),
      .rstN (rstN),
      .fd   (fdBus.decode),
      .em   (emBus.execute)
   );

   memWriteback #(.dmemWords(dmemWords)) memWb_i (
      .clk             (clk),
      .rstN            (rstN),
      .em              (emBus.memory),
      .retireValid     (retireValid),
      .retirePc        (retirePc),
      .retireRegWrite  (retireRegWrite),
      .retireRd        (retireRd),
      .retireData      (retireData),
      .retireMemRead   (retireMemRead),
      .retireMemWrite  (retireMemWrite),
      .retireAddr      (retireAddr),
      .retireStoreData (retireStoreData),
      .retireReady     (retireReady)
   );

endmodule

// File: decodeExecute.sv
`timescale 1ns/100ps

module decodeExecute import cpuPkg::*; (
   input  logic          clk,
   input  logic          rstN,
   fetchDecodeIf.decode  fd,
   execMemIf.execute     em
);

   opcodeT              opcode;
   aluOpT               aluOp;
   logic [2:0]          funct3;
   logic [6:0]          funct7;
   logic [regAddrW-1:0] rs1;
   logic [regAddrW-1:0] rs2;
   logic [regAddrW-1:0] rd;
   logic [xlen-1:0]     immI;
   logic [xlen-1:0]     immS;
   logic [xlen-1:0]     immB;
   logic [xlen-1:0]     immJ;
   logic [xlen-1:0]     rdata1;
   logic [xlen-1:0]     rdata2;
   logic [xlen-1:0]     opA;
   logic [xlen-1:0]     opB;
   logic [xlen-1:0]     aluB;
   logic [xlen-1:0]     aluOut;
   logic [xlen-1:0]     result;
   logic                isRegWrite;
   logic                taken;

   // Field extraction, register indices use the low bits only
   assign opcode = opcodeT'(fd.instr[6:0]);
   assign funct3 = fd.instr[14:12];
   assign funct7 = fd.instr[31:25];
   assign rs1    = fd.instr[15 +: regAddrW];
   assign rs2    = fd.instr[20 +: regAddrW];
   assign rd     = fd.instr[7 +: regAddrW];

   assign immI = {{20{fd.instr[31]}}, fd.instr[31:20]};
   assign immS = {{20{fd.instr[31]}}, fd.instr[31:25], fd.instr[11:7]};
   assign immB = {{19{fd.instr[31]}}, fd.instr[31], fd.instr[7], fd.instr[30:25],
                  fd.instr[11:8], 1'b0};
   assign immJ = {{11{fd.instr[31]}}, fd.instr[31], fd.instr[19:12], fd.instr[20],
                  fd.instr[30:21], 1'b0};

   // Writes come back through the forwarding pair at retirement
   regFile regFile_i (
      .clk    (clk),
      .rstN   (rstN),
      .rs1    (rs1),
      .rs2    (rs2),
      .rdata1 (rdata1),
      .rdata2 (rdata2),
      .we     (em.fwdWrite),
      .wrAddr (em.fwdRd),
      .wrData (em.fwdData)
   );

   // Bypass from the instruction retiring this cycle
   assign opA = (em.fwdWrite && em.fwdRd == rs1) ? em.fwdData : rdata1;
   assign opB = (em.fwdWrite && em.fwdRd == rs2) ? em.fwdData : rdata2;

   always_comb begin
      aluOp = ADD;
      if (opcode == OP || opcode == OPIMM) begin
         case (funct3)
            f3AddSub: aluOp = (opcode == OP && funct7 == f7Sub) ? SUB : ADD;
            f3Slt:    aluOp = SLT;
            f3Xor:    aluOp = XOR;
            f3Or:     aluOp = OR;
            f3And:    aluOp = AND;
            default:  aluOp = ADD;
         endcase
      end
   end

   always_comb begin
      case (opcode)
         OP, BRANCH: aluB = opB;
         STORE:      aluB = immS;
         default:    aluB = immI;
      endcase
   end

   always_comb begin
      case (aluOp)
         SUB:     aluOut = opA - aluB;
         AND:     aluOut = opA & aluB;
         OR:      aluOut = opA | aluB;
         XOR:     aluOut = opA ^ aluB;
         SLT:     aluOut = {{(xlen-1){1'b0}}, $signed(opA) < $signed(aluB)};
         default: aluOut = opA + aluB;
      endcase
   end

   // JAL puts its link value in the result slot
   assign result = (opcode == JAL) ? fd.pc + instrBytes : aluOut;

   assign isRegWrite = (opcode == OP) || (opcode == OPIMM) || (opcode == LOAD) ||
                       (opcode == JAL);

   always_comb begin
      taken = 1'b0;
      if (opcode == BRANCH) begin
         if (funct3 == f3Beq) begin
            taken = (opA == opB);
         end else if (funct3 == f3Bne) begin
            taken = (opA != opB);
         end
      end
   end

   assign fd.redirect   = fd.valid && (taken || opcode == JAL);
   assign fd.redirectPc = fd.pc + ((opcode == JAL) ? immJ : immB);

   always_ff @(posedge clk) begin
      if (!rstN) begin
         em.valid    <= 1'b0;
         em.regWrite <= 1'b0;
         em.memRead  <= 1'b0;
         em.memWrite <= 1'b0;
      end else if (em.advance) begin
         em.valid    <= fd.valid;
         em.regWrite <= fd.valid && isRegWrite;
         em.memRead  <= fd.valid && (opcode == LOAD);
         em.memWrite <= fd.valid && (opcode == STORE);
      end
   end

   always_ff @(posedge clk) begin
      if (em.advance) begin
         em.pc        <= fd.pc;
         em.rd        <= rd;
         em.result    <= result;
         em.storeData <= opB;
      end
   end

endmodule

// File: fetchUnit.sv
`timescale 1ns/100ps

module fetchUnit import cpuPkg::*; #(
   parameter int imemWords = 256
) (
   input  logic            clk,
   input  logic            rstN,
   input  logic            progWe,
   input  logic [xlen-1:0] progAddr,
   input  logic [xlen-1:0] progData,
   fetchDecodeIf.fetch     fd
);

   localparam int imemIdxW = $clog2(imemWords);

   logic [xlen-1:0]     imem [imemWords];
   logic [xlen-1:0]     pcReg;
   logic [imemIdxW-1:0] fetchIdx;
   logic [imemIdxW-1:0] progIdx;

   // Word index from byte addresses
   assign fetchIdx = pcReg[imemIdxW+1:2];
   assign progIdx  = progAddr[imemIdxW+1:2];

   // Program load, only while the core is held in reset
   always_ff @(posedge clk) begin
      if (!rstN && progWe) begin
         imem[progIdx] <= progData;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pcReg    <= '0;
         fd.valid <= 1'b0;
      end else if (fd.advance) begin
         if (fd.redirect) begin
            // Taken branch or jump kills the slot being fetched
            pcReg    <= fd.redirectPc;
            fd.valid <= 1'b0;
         end else begin
            pcReg    <= pcReg + instrBytes;
            fd.valid <= 1'b1;
         end
      end
   end

   // Payload of the fetch register
   always_ff @(posedge clk) begin
      if (fd.advance && !fd.redirect) begin
         fd.pc    <= pcReg;
         fd.instr <= imem[fetchIdx];
      end
   end

endmodule

// File: memWriteback.sv
`timescale 1ns/100ps

module memWriteback import cpuPkg::*; #(
   parameter int dmemWords = 256
) (
   input  logic                clk,
   input  logic                rstN,
   execMemIf.memory            em,
   output logic                retireValid,
   output logic [xlen-1:0]     retirePc,
   output logic                retireRegWrite,
   output logic [regAddrW-1:0] retireRd,
   output logic [xlen-1:0]     retireData,
   output logic                retireMemRead,
   output logic                retireMemWrite,
   output logic [xlen-1:0]     retireAddr,
   output logic [xlen-1:0]     retireStoreData,
   input  logic                retireReady
);

   localparam int dmemIdxW = $clog2(dmemWords);

   logic [xlen-1:0]     dmem [dmemWords];
   logic [dmemIdxW-1:0] dmemIdx;
   logic [xlen-1:0]     loadData;
   logic                handshake;

   assign dmemIdx   = em.result[dmemIdxW+1:2];
   assign loadData  = dmem[dmemIdx];
   assign handshake = em.valid && retireReady;

   // Freeze everything upstream while the trace port is held
   assign em.advance = !em.valid || retireReady;

   assign retireValid     = em.valid;
   assign retirePc        = em.pc;
   assign retireRegWrite  = em.regWrite && (em.rd != '0);
   assign retireRd        = em.rd;
   assign retireData      = em.memRead ? loadData : em.result;
   assign retireMemRead   = em.memRead;
   assign retireMemWrite  = em.memWrite;
   assign retireAddr      = (em.memRead || em.memWrite) ? em.result : '0;
   assign retireStoreData = em.memWrite ? em.storeData : '0;

   // Store commits on the retirement edge
   always_ff @(posedge clk) begin
      if (rstN && handshake && em.memWrite) begin
         dmem[dmemIdx] <= em.storeData;
      end
   end

   // Writeback doubles as the forwarding source
   assign em.fwdWrite = handshake && retireRegWrite;
   assign em.fwdRd    = em.rd;
   assign em.fwdData  = retireData;

endmodule

// File: regFile.sv
`timescale 1ns/100ps

module regFile import cpuPkg::*; (
   input  logic                clk,
   input  logic                rstN,
   input  logic [regAddrW-1:0] rs1,
   input  logic [regAddrW-1:0] rs2,
   output logic [xlen-1:0]     rdata1,
   output logic [xlen-1:0]     rdata2,
   input  logic                we,
   input  logic [regAddrW-1:0] wrAddr,
   input  logic [xlen-1:0]     wrData
);

   logic [xlen-1:0] regs [numRegs];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (we && wrAddr != '0) begin
         regs[wrAddr] <= wrData;
      end
   end

   // x0 is never written, so it stays zero
   assign rdata1 = regs[rs1];
   assign rdata2 = regs[rs2];

endmodule

// File: stageIf.sv
`timescale 1ns/100ps

// Fetch register to decode-execute, plus the redirect path back
interface fetchDecodeIf import cpuPkg::*; ();
   logic            valid;
   logic [xlen-1:0] pc;
   logic [xlen-1:0] instr;
   logic            redirect;
   logic [xlen-1:0] redirectPc;
   logic            advance;

   modport fetch (output valid, pc, instr,
                  input  redirect, redirectPc, advance);
   modport decode (input  valid, pc, instr, advance,
                   output redirect, redirectPc);
endinterface

// Execute register to memory-writeback, plus advance and forwarding back
interface execMemIf import cpuPkg::*; ();
   logic                valid;
   logic [xlen-1:0]     pc;
   logic                regWrite;
   logic [regAddrW-1:0] rd;
   logic [xlen-1:0]     result;
   logic                memRead;
   logic                memWrite;
   logic [xlen-1:0]     storeData;
   logic                advance;
   logic                fwdWrite;
   logic [regAddrW-1:0] fwdRd;
   logic [xlen-1:0]     fwdData;

   modport execute (output valid, pc, regWrite, rd, result, memRead, memWrite, storeData,
                    input  advance, fwdWrite, fwdRd, fwdData);
   modport memory (input  valid, pc, regWrite, rd, result, memRead, memWrite, storeData,
                   output advance, fwdWrite, fwdRd, fwdData);
endinterface

// File: tbTests.svh
// Golden model state
logic [31:0] modelRegs [8];
logic [31:0] modelMem [256];
logic [31:0] modelPc;

function automatic logic [31:0] encR(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
   return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OP};
endfunction

function automatic logic [31:0] encI(opcodeT op, logic [2:0] f3, int rd, int rs1,
                                     logic [31:0] imm);
   return {imm[11:0], 5'(rs1), f3, 5'(rd), op};
endfunction

function automatic logic [31:0] encS(int rs1, int rs2, logic [31:0] imm);
   return {imm[11:5], 5'(rs2), 5'(rs1), f3Word, imm[4:0], STORE};
endfunction

function automatic logic [31:0] encB(logic [2:0] f3, int rs1, int rs2, logic [31:0] imm);
   return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], BRANCH};
endfunction

function automatic logic [31:0] encJ(int rd, logic [31:0] imm);
   return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), JAL};
endfunction

function automatic logic [31:0] modelAlu(aluOpT op, logic [31:0] a, logic [31:0] b);
   case (op)
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLT:     return {31'b0, $signed(a) < $signed(b)};
      default: return a + b;
   endcase
endfunction

task automatic checkVal(string name, logic [31:0] got, logic [31:0] exp);
   if (got !== exp) begin
      $display("** Error %s: got %h, expected %h", name, got, exp);
      errorCount++;
   end
endtask

// Steps the ISA model one instruction and checks the trace port against it
task automatic stepAndCheck();
   logic [31:0] instr;
   logic [31:0] a;
   logic [31:0] b;
   logic [31:0] data;
   logic [31:0] addr;
   logic [31:0] nextPc;
   logic [2:0]  f3;
   logic [2:0]  rd;
   logic        writes;
   aluOpT       op;
   instr  = ((modelPc >> 2) < prog.size()) ? prog[modelPc[31:2]] : 32'h0;
   f3     = instr[14:12];
   rd     = instr[9:7];
   a      = modelRegs[instr[17:15]];
   b      = modelRegs[instr[22:20]];
   data   = '0;
   addr   = '0;
   writes = 1'b0;
   nextPc = modelPc + 4;
   case (f3)
      3'b000:  op = (instr[6:0] == OP && instr[31:25] == f7Sub) ? SUB : ADD;
      3'b010:  op = SLT;
      3'b100:  op = XOR;
      3'b110:  op = OR;
      default: op = AND;
   endcase
   checkVal("retirePc", retirePc, modelPc);
   case (instr[6:0])
      OP: begin
         data   = modelAlu(op, a, b);
         writes = 1'b1;
      end
      OPIMM: begin
         data   = modelAlu(op, a, {{20{instr[31]}}, instr[31:20]});
         writes = 1'b1;
      end
      LOAD: begin
         addr   = a + {{20{instr[31]}}, instr[31:20]};
         data   = modelMem[addr[9:2]];
         writes = 1'b1;
      end
      STORE: begin
         addr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
         modelMem[addr[9:2]] = b;
         checkVal("retireStoreData", retireStoreData, b);
      end
      BRANCH: begin
         if ((f3 == f3Beq) ? (a == b) : (a != b)) begin
            nextPc = modelPc + {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                instr[11:8], 1'b0};
         end
      end
      default: begin
         data   = modelPc + 4;
         writes = 1'b1;
         nextPc = modelPc + {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                             instr[30:21], 1'b0};
      end
   endcase
   checkVal("retireRegWrite", 32'(retireRegWrite), 32'(writes && rd != 0));
   checkVal("retireMemRead", 32'(retireMemRead), 32'(instr[6:0] == LOAD));
   checkVal("retireMemWrite", 32'(retireMemWrite), 32'(instr[6:0] == STORE));
   checkVal("retireAddr", retireAddr, addr);
   if (writes) begin
      checkVal("retireRd", 32'(retireRd), 32'(rd));
      checkVal("retireData", retireData, data);
   end
   if (writes && rd != 0) begin
      modelRegs[rd] = data;
   end
   modelPc = nextPc;
endtask

task automatic loadProgram();
   int n;
   n = (prog.size() > resetCycles) ? prog.size() : resetCycles;
   @(posedge clk);
   rstN        <= 1'b0;
   retireReady <= 1'b1;
   for (int i = 0; i < n; i++) begin
      @(posedge clk);
      progWe   <= (i < prog.size());
      progAddr <= 32'(i * 4);
      progData <= (i < prog.size()) ? prog[i] : 32'h0;
   end
   @(posedge clk);
   progWe <= 1'b0;
   rstN   <= 1'b1;
   for (int r = 0; r < 8; r++) begin
      modelRegs[r] = '0;
   end
   modelPc = '0;
   @(negedge clk);
   checkVal("retireValid", 32'(retireValid), 32'h0);
endtask

// Runs until n retirements with optional random back-pressure
task automatic runRetires(int n, logic backPressure);
   int           count;
   logic         held;
   logic [134:0] snapshot;
   count = 0;
   held  = 1'b0;
   while (count < n) begin
      @(posedge clk);
      retireReady <= backPressure ? 1'($urandom_range(0, 1)) : 1'b1;
      @(negedge clk);
      if (held && traceNow !== snapshot) begin
         $display("Trace port changed while retireReady was low at pc %h", snapshot[133:102]);
         errorCount++;
      end
      held = 1'b0;
      if (retireValid) begin
         if (retireReady) begin
            stepAndCheck();
            count++;
         end else begin
            snapshot = traceNow;
            held     = 1'b1;
         end
      end
   end
   @(posedge clk);
   retireReady <= 1'b1;
endtask

task automatic aluTest();
   prog = {encI(OPIMM, f3AddSub, 1, 0, 5), encI(OPIMM, f3AddSub, 2, 0, -3),
           encR(7'b0, f3AddSub, 3, 1, 2), encR(f7Sub, f3AddSub, 4, 1, 2),
           encR(7'b0, f3And, 5, 1, 2), encR(7'b0, f3Or, 6, 1, 2),
           encR(7'b0, f3Xor, 7, 1, 2), encR(7'b0, f3Slt, 3, 2, 1),
           encI(OPIMM, f3AddSub, 0, 1, 7), encR(7'b0, f3AddSub, 0, 1, 1), encJ(0, 0)};
   loadProgram();
   runRetires(aluRetires, 1'b0);
endtask

task automatic forwardTest();
   prog = {encI(OPIMM, f3AddSub, 1, 0, 100), encI(OPIMM, f3AddSub, 1, 1, 1),
           encR(7'b0, f3AddSub, 2, 1, 1), encS(0, 2, 8), encI(LOAD, f3Word, 3, 0, 8),
           encR(7'b0, f3AddSub, 4, 3, 3), encR(f7Sub, f3AddSub, 5, 4, 1), encJ(0, 0)};
   loadProgram();
   runRetires(forwardRetires, 1'b0);
endtask

task automatic memoryTest();
   prog = {encI(OPIMM, f3AddSub, 1, 0, 64), encI(OPIMM, f3AddSub, 2, 0, 'h123),
           encS(1, 2, 0), encS(1, 1, 4), encR(7'b0, f3Xor, 3, 2, 1), encS(1, 3, -4),
           encI(LOAD, f3Word, 4, 1, 0), encI(LOAD, f3Word, 5, 1, 4),
           encI(LOAD, f3Word, 6, 1, -4), encJ(0, 0)};
   loadProgram();
   runRetires(memoryRetires, 1'b0);
endtask

task automatic controlTest(logic backPressure);
   prog = {encI(OPIMM, f3AddSub, 1, 0, 1), encI(OPIMM, f3AddSub, 2, 0, 1),
           encB(f3Beq, 1, 2, 8), encI(OPIMM, f3AddSub, 3, 0, 99),
           encB(f3Bne, 1, 2, 8), encI(OPIMM, f3AddSub, 4, 0, 7),
           encB(f3Bne, 4, 1, 8), encI(OPIMM, f3AddSub, 5, 0, 55),
           encB(f3Beq, 4, 1, 8), encJ(6, 8), encI(OPIMM, f3AddSub, 7, 0, 77),
           encR(7'b0, f3AddSub, 7, 6, 4), encJ(0, 0)};
   loadProgram();
   runRetires(controlRetires, backPressure);
endtask

// File: tbCpu.sv
`timescale 1ns/100ps

module tbCpu import cpuPkg::*;;

   localparam int clkPeriod      = 4;
   localparam int resetCycles    = 10;
   localparam int aluRetires     = 13;
   localparam int forwardRetires = 10;
   localparam int memoryRetires  = 12;
   localparam int controlRetires = 14;
   localparam int totalRetires   = aluRetires + forwardRetires + memoryRetires +
                                   2 * controlRetires;
   localparam int cyclesPerRet   = 20;

   logic                clk;
   logic                rstN;
   logic                progWe;
   logic [xlen-1:0]     progAddr;
   logic [xlen-1:0]     progData;
   logic                retireValid;
   logic [xlen-1:0]     retirePc;
   logic                retireRegWrite;
   logic [regAddrW-1:0] retireRd;
   logic [xlen-1:0]     retireData;
   logic                retireMemRead;
   logic                retireMemWrite;
   logic [xlen-1:0]     retireAddr;
   logic [xlen-1:0]     retireStoreData;
   logic                retireReady;

   // Whole trace port for spotting changes while held
   logic [134:0]        traceNow;

   int                  errorCount;
   logic [31:0]         prog [$];

   assign traceNow = {retireValid, retirePc, retireRegWrite, retireRd, retireData,
                      retireMemRead, retireMemWrite, retireAddr, retireStoreData};

   cpuTop dut_i (
      .clk             (clk),
      .rstN            (rstN),
      .progWe          (progWe),
      .progAddr        (progAddr),
      .progData        (progData),
      .retireValid     (retireValid),
      .retirePc        (retirePc),
      .retireRegWrite  (retireRegWrite),
      .retireRd        (retireRd),
      .retireData      (retireData),
      .retireMemRead   (retireMemRead),
      .retireMemWrite  (retireMemWrite),
      .retireAddr      (retireAddr),
      .retireStoreData (retireStoreData),
      .retireReady     (retireReady)
   );

   initial begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   `include "tbTests.svh"

   initial begin
      #(totalRetires * cyclesPerRet * clkPeriod);
      $display("Timeout: the pipeline stopped retiring instructions");
      $display("Done: errors found");
      $finish;
   end

   initial begin
      rstN        = 1'b0;
      progWe      = 1'b0;
      progAddr    = '0;
      progData    = '0;
      retireReady = 1'b0;
      errorCount  = 0;
      void'($urandom(32'h0bd995c6));

      aluTest();
      forwardTest();
      memoryTest();
      controlTest(1'b0);
      controlTest(1'b1);

      $display("Checks finished with %0d errors", errorCount);
      if (errorCount == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule
